// ==== Makefile ====
TOP := tb_lsu

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f flist.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== bench/lsu_checker.sv ====
module lsu_checker (
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic        i_wb_valid,
  input  logic [4:0]  i_wb_rd,
  input  logic [31:0] i_wb_data,
  input  logic        i_retire,
  input  logic        i_halted,
  output logic        o_done,
  output int          o_value_errors,
  output int          o_other_errors
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [4:0]  exp_rd_q [$];
  logic [31:0] exp_data_q [$];
  int          exp_retires = 0;
  int          retire_count = 0;
  int          wb_index = 0;
  int          value_err_count = 0;
  int          other_err_count = 0;
  logic        halt_seen = 1'b0;

  task automatic add_writeback(input logic [4:0] rd, input logic [31:0] data);
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(data);
  endtask

  task automatic set_retire_count(input int count);
    exp_retires = count;
  endtask

  task automatic report_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    $display("** Error %s: expected %h, actual %h", name, exp, act);
    value_err_count++;
  endtask

  task automatic check_writeback();
    string name;
    if (exp_rd_q.size() == 0) begin
      $display("Writeback of %h to x%0d arrived after all expected writebacks",
               i_wb_data, i_wb_rd);
      other_err_count++;
    end else begin
      name = $sformatf("writeback %0d", wb_index);
      if (i_wb_rd !== exp_rd_q[0]) begin
        report_value({name, " rd"}, {27'd0, exp_rd_q[0]}, {27'd0, i_wb_rd});
      end
      if (i_wb_data !== exp_data_q[0]) begin
        report_value({name, " data"}, exp_data_q[0], i_wb_data);
      end
      void'(exp_rd_q.pop_front());
      void'(exp_data_q.pop_front());
      wb_index++;
    end
  endtask

  task automatic check_halt();
    if (retire_count != exp_retires) begin
      report_value("retire count", exp_retires, retire_count);
    end
    if (exp_rd_q.size() != 0) begin
      $display("Core halted with %0d expected writebacks never seen", exp_rd_q.size());
      other_err_count++;
    end
  endtask

  // Outputs are registered, so the falling edge sees settled values
  always @(negedge i_clk) begin
    if (i_rst_n && !halt_seen) begin
      if (i_retire) begin
        retire_count++;
      end
      if (i_wb_valid) begin
        check_writeback();
      end
      if (i_halted) begin
        check_halt();
        halt_seen = 1'b1;
      end
    end
  end

  assign o_done         = halt_seen;
  assign o_value_errors = value_err_count;
  assign o_other_errors = other_err_count;

endmodule

// ==== bench/lsu_stim.txt ====
# M <word index hex> <data hex> preloads memory through the host port
# E <rd decimal> <value hex> is the next expected writeback, R <count> the retires at halt
M 00 10002083  # lw   x1, 0x100(x0)
M 01 10000103  # lb   x2, 0x100(x0)
M 02 10100183  # lb   x3, 0x101(x0)
M 03 10204203  # lbu  x4, 0x102(x0)
M 04 10300283  # lb   x5, 0x103(x0)
M 05 10001303  # lh   x6, 0x100(x0)
M 06 10201383  # lh   x7, 0x102(x0)
M 07 10205403  # lhu  x8, 0x102(x0)
M 08 10002003  # lw   x0, 0x100(x0)
M 09 00000013  # addi, no-op here
M 0a 10702223  # sw   x7, 0x104(x0)
M 0b 104003a3  # sb   x4, 0x107(x0)
M 0c 10301223  # sh   x3, 0x104(x0)
M 0d 10402483  # lw   x9, 0x104(x0)
M 0e 0000006f  # jal, no-op here
M 0f 10605503  # lhu  x10, 0x106(x0)
M 10 00000000  # halt
M 40 876543a1  # data at 0x100
M 41 1234f00d  # data at 0x104, overwritten by the stores
E 1 876543a1
E 2 ffffffa1
E 3 00000043
E 4 00000065
E 5 ffffff87
E 6 000043a1
E 7 ffff8765
E 8 00008765
E 9 65ff0043
E 10 000065ff
R 16

// ==== bench/tb_lsu.sv ====
module tb_lsu import lsu_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int          CLK_HALF         = 50;
  localparam int          RST_CYCLES       = 10;
  localparam int          CYCLES_PER_INSTR = 40;
  localparam int          TIMEOUT_BASE     = 200;
  localparam logic [15:0] LFSR_SEED        = 16'd52;
  localparam string       STIM_FILE        = "bench/lsu_stim.txt";

  logic              clk = 1'b0;
  logic              rst_n;
  logic              run;
  logic              mem_wait;
  logic              host_we;
  logic [RAM_AW-1:0] host_addr;
  logic [31:0]       host_data;
  logic              wb_valid;
  logic [4:0]        wb_rd;
  logic [31:0]       wb_data;
  logic              retire;
  logic              halted;
  logic              check_done;
  int                value_errors;
  int                other_errors;

  logic [RAM_AW-1:0] preload_addr_q [$];
  logic [31:0]       preload_data_q [$];
  int                exp_retires = 0;
  int                timeout_limit = 0;
  int                run_cycles = 0;
  logic [15:0]       lfsr;
  bit                stim_ok;

  always #CLK_HALF clk = ~clk;

  // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    lfsr_next = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  task automatic read_stim(output bit ok);
    int          fd;
    int          n;
    string       line;
    logic [31:0] a;
    logic [31:0] b;
    ok = 1'b0;
    fd = $fopen(STIM_FILE, "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 2) begin
          case (line[0])
            "M": begin
              n = $sscanf(line.substr(2, line.len() - 1), "%h %h", a, b);
              preload_addr_q.push_back(a[RAM_AW-1:0]);
              preload_data_q.push_back(b);
            end
            "E": begin
              n = $sscanf(line.substr(2, line.len() - 1), "%d %h", a, b);
              u_lsu_checker.add_writeback(a[4:0], b);
            end
            "R": begin
              n = $sscanf(line.substr(2, line.len() - 1), "%d", a);
              exp_retires = int'(a);
              u_lsu_checker.set_retire_count(exp_retires);
            end
            default: ; // Comment lines
          endcase
        end
      end
      $fclose(fd);
    end
  endtask

  // One host write per cycle while the core is stopped
  task automatic preload_memory();
    for (int i = 0; i < preload_addr_q.size(); i++) begin
      @(posedge clk);
      #1;
      host_we   = 1'b1;
      host_addr = preload_addr_q[i];
      host_data = preload_data_q[i];
    end
    @(posedge clk);
    #1 host_we = 1'b0;
  endtask

  initial begin
    mem_wait = 1'b0;
    lfsr     = LFSR_SEED;
    forever begin
      @(posedge clk);
      #1;
      lfsr     = lfsr_next(lfsr);
      mem_wait = lfsr[0]; // One bit per step
    end
  end

  initial begin
    rst_n     = 1'b0;
    run       = 1'b0;
    host_we   = 1'b0;
    host_addr = '0;
    host_data = '0;
    read_stim(stim_ok);
    if (!stim_ok) begin
      $display("Cannot open stimulus file %s", STIM_FILE);
      $display("Some tests failed");
      $finish;
    end else begin
      timeout_limit = CYCLES_PER_INSTR * (exp_retires + 1) + TIMEOUT_BASE;
      repeat (RST_CYCLES) @(posedge clk);
      #1 rst_n = 1'b1;
      preload_memory();
      @(posedge clk);
      #1 run = 1'b1;
      wait (check_done);
      @(posedge clk);
      $display("Error counts: %0d value mismatches, %0d other failures",
               value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
        $display("All tests passed");
      end else begin
        $display("Some tests failed");
      end
      $finish;
    end
  end

  always @(posedge clk) begin
    if (run && !check_done) begin
      run_cycles++;
      if (run_cycles > timeout_limit) begin
        $display("Run timed out before halt after %0d cycles", run_cycles);
        $display("Some tests failed");
        $finish;
      end
    end
  end

  lsu_top u_lsu_top (
    .i_clk       (clk),
    .i_rst_n     (rst_n),
    .i_run       (run),
    .i_mem_wait  (mem_wait),
    .i_host_we   (host_we),
    .i_host_addr (host_addr),
    .i_host_data (host_data),
    .o_wb_valid  (wb_valid),
    .o_wb_rd     (wb_rd),
    .o_wb_data   (wb_data),
    .o_retire    (retire),
    .o_halted    (halted)
  );

  lsu_checker u_lsu_checker (
    .i_clk          (clk),
    .i_rst_n        (rst_n),
    .i_wb_valid     (wb_valid),
    .i_wb_rd        (wb_rd),
    .i_wb_data      (wb_data),
    .i_retire       (retire),
    .i_halted       (halted),
    .o_done         (check_done),
    .o_value_errors (value_errors),
    .o_other_errors (other_errors)
  );

endmodule

// ==== flist.f ====
hdl/lsu_pkg.sv
hdl/instr_sequencer.sv
hdl/load_store.sv
hdl/word_ram.sv
hdl/lsu_top.sv
bench/lsu_checker.sv
bench/tb_lsu.sv

// ==== hdl/instr_sequencer.sv ====
module instr_sequencer import lsu_pkg::*; (
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic        i_run,
  input  logic        i_ir_dv,
  input  logic [31:0] i_ir_value,
  input  logic        i_loaded_dv,
  input  logic [31:0] i_loaded_value,
  input  logic        i_ld_st_done,
  output logic        o_exec,
  output logic        o_start_fetch,
  output logic [31:0] o_pc,
  output ls_op_t      o_op,
  output logic [31:0] o_base,
  output logic [31:0] o_store_data,
  output logic [31:0] o_offset,
  output logic        o_wb_valid,
  output logic [4:0]  o_wb_rd,
  output logic [31:0] o_wb_data,
  output logic        o_retire,
  output logic        o_halted
);

  logic [31:0] rf [32];
  logic [31:0] r_ir;
  logic [31:0] r_pc;
  logic        r_exec;
  logic        r_started;
  logic        r_start_fetch;
  logic        r_retire;
  logic        r_wb_valid;
  logic        r_halted;

  logic [6:0]  w_opcode;
  logic [2:0]  w_funct3;
  logic [4:0]  w_rd;
  logic [4:0]  w_rs1;
  logic [4:0]  w_rs2;
  ls_op_t      w_op;
  logic        w_is_store;
  logic        w_halt_now;
  logic        w_retire_now;

  assign w_opcode = r_ir[6:0];
  assign w_funct3 = r_ir[14:12];
  assign w_rd     = r_ir[11:7];
  assign w_rs1    = r_ir[19:15];
  assign w_rs2    = r_ir[24:20];

  always_comb begin
    w_op = OP_NONE;
    if (w_opcode == OPC_LOAD) begin
      case (w_funct3)
        F3_B:    w_op = OP_LB;
        F3_H:    w_op = OP_LH;
        F3_W:    w_op = OP_LW;
        F3_BU:   w_op = OP_LBU;
        F3_HU:   w_op = OP_LHU;
        default: w_op = OP_NONE;
      endcase
    end else if (w_opcode == OPC_STORE) begin
      case (w_funct3)
        F3_B:    w_op = OP_SB;
        F3_H:    w_op = OP_SH;
        F3_W:    w_op = OP_SW;
        default: w_op = OP_NONE;
      endcase
    end
  end

  assign w_is_store = (w_op == OP_SB) || (w_op == OP_SH) || (w_op == OP_SW);
  assign w_halt_now = r_exec && (r_ir == 32'd0);
  assign w_retire_now = r_exec && !w_halt_now &&
                        ((w_op == OP_NONE) || (w_is_store && i_ld_st_done) || i_loaded_dv);

  // S-format splits the immediate around rd
  assign o_offset = (w_opcode == OPC_STORE) ?
                    {{20{r_ir[31]}}, r_ir[31:25], r_ir[11:7]} :
                    {{20{r_ir[31]}}, r_ir[31:20]};

  assign o_base       = (w_rs1 == 5'd0) ? 32'd0 : rf[w_rs1];
  assign o_store_data = (w_rs2 == 5'd0) ? 32'd0 : rf[w_rs2];
  assign o_op         = w_op;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_pc          <= 32'd0;
      r_exec        <= 1'b0;
      r_started     <= 1'b0;
      r_start_fetch <= 1'b0;
      r_retire      <= 1'b0;
      r_wb_valid    <= 1'b0;
      r_halted      <= 1'b0;
    end else begin
      r_start_fetch <= i_run && (!r_started || r_retire); // First fetch or next one
      r_retire      <= w_retire_now;
      r_wb_valid    <= w_retire_now && i_loaded_dv && (w_rd != 5'd0);
      if (i_run) begin
        r_started <= 1'b1;
      end
      if (i_ir_dv) begin
        r_exec <= 1'b1;
      end else if (w_retire_now || w_halt_now) begin
        r_exec <= 1'b0;
      end
      if (w_retire_now) begin
        r_pc <= r_pc + 32'd4;
      end
      if (w_halt_now) begin
        r_halted <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_ir_dv) begin
      r_ir <= i_ir_value;
    end
    if (r_exec && i_loaded_dv) begin
      o_wb_rd   <= w_rd;
      o_wb_data <= i_loaded_value;
      if (w_rd != 5'd0) begin
        rf[w_rd] <= i_loaded_value; // x0 stays zero
      end
    end
  end

  assign o_pc          = r_pc;
  assign o_exec        = r_exec;
  assign o_start_fetch = r_start_fetch;
  assign o_retire      = r_retire;
  assign o_wb_valid    = r_wb_valid;
  assign o_halted      = r_halted;

  a_retire_not_halted: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_retire && o_halted));

  a_no_fetch_in_exec: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_start_fetch && o_exec));

endmodule

// ==== hdl/load_store.sv ====
module load_store import lsu_pkg::*; (
  input  logic        i_clk,
  input  logic        i_rst_n,
  input  logic        i_exec,
  input  logic        i_start_fetch,
  input  ls_op_t      i_op,
  input  logic [31:0] i_pc,
  input  logic [31:0] i_base,
  input  logic [31:0] i_store_data,
  input  logic [31:0] i_offset,
  input  logic        i_rsp_dv,
  input  logic [31:0] i_rsp_data,
  output logic        o_bus_dv,
  output logic [31:0] o_bus_address,
  output logic [31:0] o_bus_data,
  output logic [2:0]  o_bus_size,
  output logic        o_write_notread,
  output logic [31:0] o_ir_value,
  output logic        o_ir_dv,
  output logic [31:0] o_loaded_value,
  output logic        o_loaded_dv,
  output logic        o_ld_st_done
);

  typedef enum logic {
    READY   = 1'b0,
    WAITING = 1'b1
  } bus_state_t;

  bus_state_t r_state;
  logic       r_data_issued;
  logic       r_bus_open;
  logic       w_is_load;
  logic       w_is_data;
  logic       w_issue_fetch;
  logic       w_issue_data;

  function automatic logic [2:0] op_size(input ls_op_t op);
    case (op)
      OP_LB, OP_LBU, OP_SB: op_size = SZ_BYTE;
      OP_LH, OP_LHU, OP_SH: op_size = SZ_HALF;
      default:              op_size = SZ_WORD;
    endcase
  endfunction

  function automatic logic [31:0] extend(input ls_op_t op, input logic [31:0] data);
    case (op)
      OP_LB:   extend = {{24{data[7]}}, data[7:0]};
      OP_LH:   extend = {{16{data[15]}}, data[15:0]};
      OP_LBU:  extend = {24'd0, data[7:0]};
      OP_LHU:  extend = {16'd0, data[15:0]};
      default: extend = data;
    endcase
  endfunction

  function automatic logic [31:0] store_lanes(input ls_op_t op, input logic [31:0] data);
    case (op)
      OP_SB:   store_lanes = {24'd0, data[7:0]};
      OP_SH:   store_lanes = {16'd0, data[15:0]};
      default: store_lanes = data;
    endcase
  endfunction

  assign w_is_load = (i_op == OP_LB) || (i_op == OP_LH) || (i_op == OP_LW) ||
                     (i_op == OP_LBU) || (i_op == OP_LHU);
  assign w_is_data = (i_op != OP_NONE);

  assign w_issue_fetch = !i_exec && (r_state == READY) && i_start_fetch;
  assign w_issue_data  = i_exec && (r_state == READY) && w_is_data && !r_data_issued;

  assign o_ld_st_done = i_exec && w_is_data && (r_state == WAITING) && i_rsp_dv;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_state       <= READY;
      r_data_issued <= 1'b0;
      o_bus_dv      <= 1'b0;
      o_ir_dv       <= 1'b0;
      o_loaded_dv   <= 1'b0;
    end else begin
      o_bus_dv    <= w_issue_fetch || w_issue_data;
      o_ir_dv     <= !i_exec && (r_state == WAITING) && i_rsp_dv;
      o_loaded_dv <= o_ld_st_done && w_is_load;
      if (w_issue_fetch || w_issue_data) begin
        r_state <= WAITING;
      end else if ((r_state == WAITING) && i_rsp_dv) begin
        r_state <= READY;
      end
      if (!i_exec) begin
        r_data_issued <= 1'b0; // One data access per execute phase
      end else if (w_issue_data) begin
        r_data_issued <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_issue_fetch) begin
      o_bus_address   <= i_pc;
      o_bus_size      <= SZ_WORD;
      o_write_notread <= 1'b0;
    end else if (w_issue_data) begin
      o_bus_address   <= i_base + i_offset;
      o_bus_size      <= op_size(i_op);
      o_bus_data      <= store_lanes(i_op, i_store_data);
      o_write_notread <= !w_is_load;
    end
    if (!i_exec && (r_state == WAITING) && i_rsp_dv) begin
      o_ir_value <= i_rsp_data;
    end
    if (o_ld_st_done && w_is_load) begin
      o_loaded_value <= extend(i_op, i_rsp_data);
    end
  end

  // Request seen on the bus and not yet answered
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_bus_open <= 1'b0;
    end else if (o_bus_dv) begin
      r_bus_open <= 1'b1;
    end else if (i_rsp_dv) begin
      r_bus_open <= 1'b0;
    end
  end

  a_no_issue_waiting: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_bus_dv |-> !r_bus_open);

  a_loaded_is_load: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_loaded_dv |-> (i_exec && w_is_load));

endmodule

// ==== hdl/lsu_pkg.sv ====
package lsu_pkg;

  // Decoded load/store operation
  typedef enum logic [3:0] {
    OP_NONE = 4'd0,
    OP_LB   = 4'd1,
    OP_LH   = 4'd2,
    OP_LW   = 4'd3,
    OP_LBU  = 4'd4,
    OP_LHU  = 4'd5,
    OP_SB   = 4'd6,
    OP_SH   = 4'd7,
    OP_SW   = 4'd8
  } ls_op_t;

  // One-hot access size on the bus
  localparam logic [2:0] SZ_BYTE = 3'b001;
  localparam logic [2:0] SZ_HALF = 3'b010;
  localparam logic [2:0] SZ_WORD = 3'b100;

  // Memory geometry in 32-bit words
  localparam int RAM_WORDS = 256;
  localparam int RAM_AW    = $clog2(RAM_WORDS);

  // Major opcodes
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  // funct3 values shared by loads and stores
  localparam logic [2:0] F3_B  = 3'b000;
  localparam logic [2:0] F3_H  = 3'b001;
  localparam logic [2:0] F3_W  = 3'b010;
  localparam logic [2:0] F3_BU = 3'b100;
  localparam logic [2:0] F3_HU = 3'b101;

endpackage

// ==== hdl/lsu_top.sv ====
module lsu_top import lsu_pkg::*; (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_run,
  input  logic              i_mem_wait,
  input  logic              i_host_we,
  input  logic [RAM_AW-1:0] i_host_addr,
  input  logic [31:0]       i_host_data,
  output logic              o_wb_valid,
  output logic [4:0]        o_wb_rd,
  output logic [31:0]       o_wb_data,
  output logic              o_retire,
  output logic              o_halted
);

  logic        exec;
  logic        start_fetch;
  logic [31:0] pc;
  ls_op_t      op;
  logic [31:0] base;
  logic [31:0] store_data;
  logic [31:0] offset;
  logic        ir_dv;
  logic [31:0] ir_value;
  logic        loaded_dv;
  logic [31:0] loaded_value;
  logic        ld_st_done;
  logic        bus_dv;
  logic [31:0] bus_address;
  logic [31:0] bus_data;
  logic [2:0]  bus_size;
  logic        write_notread;
  logic        rsp_dv;
  logic [31:0] rsp_data;

  instr_sequencer u_instr_sequencer (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_run          (i_run),
    .i_ir_dv        (ir_dv),
    .i_ir_value     (ir_value),
    .i_loaded_dv    (loaded_dv),
    .i_loaded_value (loaded_value),
    .i_ld_st_done   (ld_st_done),
    .o_exec         (exec),
    .o_start_fetch  (start_fetch),
    .o_pc           (pc),
    .o_op           (op),
    .o_base         (base),
    .o_store_data   (store_data),
    .o_offset       (offset),
    .o_wb_valid     (o_wb_valid),
    .o_wb_rd        (o_wb_rd),
    .o_wb_data      (o_wb_data),
    .o_retire       (o_retire),
    .o_halted       (o_halted)
  );

  load_store u_load_store (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_exec          (exec),
    .i_start_fetch   (start_fetch),
    .i_op            (op),
    .i_pc            (pc),
    .i_base          (base),
    .i_store_data    (store_data),
    .i_offset        (offset),
    .i_rsp_dv        (rsp_dv),
    .i_rsp_data      (rsp_data),
    .o_bus_dv        (bus_dv),
    .o_bus_address   (bus_address),
    .o_bus_data      (bus_data),
    .o_bus_size      (bus_size),
    .o_write_notread (write_notread),
    .o_ir_value      (ir_value),
    .o_ir_dv         (ir_dv),
    .o_loaded_value  (loaded_value),
    .o_loaded_dv     (loaded_dv),
    .o_ld_st_done    (ld_st_done)
  );

  word_ram u_word_ram (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_bus_dv        (bus_dv),
    .i_bus_address   (bus_address),
    .i_bus_data      (bus_data),
    .i_bus_size      (bus_size),
    .i_write_notread (write_notread),
    .i_mem_wait      (i_mem_wait),
    .i_host_we       (i_host_we && !i_run), // Preload only while stopped
    .i_host_addr     (i_host_addr),
    .i_host_data     (i_host_data),
    .o_rsp_dv        (rsp_dv),
    .o_rsp_data      (rsp_data)
  );

endmodule

// ==== hdl/word_ram.sv ====
module word_ram import lsu_pkg::*; (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_bus_dv,
  input  logic [31:0]       i_bus_address,
  input  logic [31:0]       i_bus_data,
  input  logic [2:0]        i_bus_size,
  input  logic              i_write_notread,
  input  logic              i_mem_wait,
  input  logic              i_host_we,
  input  logic [RAM_AW-1:0] i_host_addr,
  input  logic [31:0]       i_host_data,
  output logic              o_rsp_dv,
  output logic [31:0]       o_rsp_data
);

  logic [31:0]       mem [RAM_WORDS];
  logic              r_pending;
  logic [31:0]       r_addr;
  logic [31:0]       r_data;
  logic [2:0]        r_size;
  logic              r_wnr;

  logic [31:0]       w_addr;
  logic [31:0]       w_data;
  logic [2:0]        w_size;
  logic              w_wnr;
  logic              w_access;
  logic [RAM_AW-1:0] w_idx;
  logic [31:0]       w_word;
  logic [3:0]        w_be;
  logic [31:0]       w_wdata;
  logic [31:0]       w_rdata;

  // A fresh request is served straight from the bus
  assign w_addr   = i_bus_dv ? i_bus_address : r_addr;
  assign w_data   = i_bus_dv ? i_bus_data : r_data;
  assign w_size   = i_bus_dv ? i_bus_size : r_size;
  assign w_wnr    = i_bus_dv ? i_write_notread : r_wnr;
  assign w_access = (i_bus_dv || r_pending) && !i_mem_wait;
  assign w_idx    = w_addr[RAM_AW+1:2];
  assign w_word   = mem[w_idx];

  always_comb begin
    case (w_size)
      SZ_BYTE: begin
        w_be    = 4'b0001 << w_addr[1:0];
        w_wdata = {4{w_data[7:0]}};
        w_rdata = {24'd0, w_word[{w_addr[1:0], 3'b000} +: 8]};
      end
      SZ_HALF: begin
        w_be    = w_addr[1] ? 4'b1100 : 4'b0011;
        w_wdata = {2{w_data[15:0]}};
        w_rdata = {16'd0, (w_addr[1] ? w_word[31:16] : w_word[15:0])};
      end
      default: begin
        w_be    = 4'b1111;
        w_wdata = w_data;
        w_rdata = w_word;
      end
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      r_pending <= 1'b0;
      o_rsp_dv  <= 1'b0;
    end else begin
      o_rsp_dv <= w_access;
      if (w_access) begin
        r_pending <= 1'b0;
      end else if (i_bus_dv) begin
        r_pending <= 1'b1; // Held off by i_mem_wait
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_bus_dv) begin
      r_addr <= i_bus_address;
      r_data <= i_bus_data;
      r_size <= i_bus_size;
      r_wnr  <= i_write_notread;
    end
    if (w_access && !w_wnr) begin
      o_rsp_data <= w_rdata;
    end
    if (i_host_we) begin
      mem[i_host_addr] <= i_host_data;
    end else if (w_access && w_wnr) begin
      for (int b = 0; b < 4; b++) begin
        if (w_be[b]) begin
          mem[w_idx][8*b +: 8] <= w_wdata[8*b +: 8];
        end
      end
    end
  end

  a_single_outstanding: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_bus_dv |-> !r_pending);

endmodule
